/* src/rv_fetch_params.svh */
// rv_fetch parameters: datapath widths, reset pc and instruction memory depth
`ifndef RV_FETCH_PARAMS_SVH
`define RV_FETCH_PARAMS_SVH

`define RV_FETCH_PC_WD          32
`define RV_FETCH_INST_WD        32
`define RV_FETCH_SRAM_DATA_WD   64
`define RV_FETCH_SRAM_ADDR_WD   6   // 64 words, 128 instructions

// first fetch address after reset
`define RV_FETCH_PC_RESETVAL    32'h0000_0000

`define RV_FETCH_SRAM_DEPTH     (1 << `RV_FETCH_SRAM_ADDR_WD)

`endif

/* src/rv_fetch_pkg.sv */
// rv_fetch package: pc, instruction and instruction memory types
`include "rv_fetch_params.svh"

package rv_fetch_pkg;

  // byte address of an instruction
  typedef logic [`RV_FETCH_PC_WD-1:0] pc_t;

  // one rv32 instruction
  typedef logic [`RV_FETCH_INST_WD-1:0] inst_t;

  // word index into the 64-bit wide memory
  typedef logic [`RV_FETCH_SRAM_ADDR_WD-1:0] sram_addr_t;

  // two instructions per word, lower address in the low half
  typedef logic [`RV_FETCH_SRAM_DATA_WD-1:0] sram_data_t;

endpackage

/* src/rv_fetch_pc.sv */
// rv_fetch program counter: next-pc choice and instruction memory read request
`include "rv_fetch_params.svh"

module rv_fetch_pc (
  input  logic                     i_clk,
  input  logic                     i_reset,
  input  logic                     i_load,       // IF ready for the next word
  input  logic                     i_br_taken,
  input  rv_fetch_pkg::pc_t        i_br_target,
  output rv_fetch_pkg::pc_t        o_pc,
  output logic                     o_sram_ren,
  output rv_fetch_pkg::sram_addr_t o_sram_addr
);

  import rv_fetch_pkg::*;

  // byte offset bits inside one memory word
  localparam int unsigned WORD_LSB = $clog2(`RV_FETCH_SRAM_DATA_WD / 8);

  pc_t pc;
  pc_t seq_pc;
  pc_t next_pc;

  assign seq_pc  = pc + pc_t'(4);
  assign next_pc = i_br_taken ? i_br_target : seq_pc;  // jal redirect from ID

  // sits one below the reset pc so the first load lands on it
  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      pc <= pc_t'(`RV_FETCH_PC_RESETVAL - 32'd4);
    end else if (i_load) begin
      pc <= next_pc;
    end
  end

  // read issued with the pc update, so rdata and pc line up next cycle
  assign o_sram_ren  = i_load;
  assign o_sram_addr = next_pc[WORD_LSB +: $bits(sram_addr_t)];
  assign o_pc        = pc;

endmodule

/* src/rv_fetch_inst_sram.sv */
// rv_fetch instruction memory: 64-bit words, registered read, write port for loading
`include "rv_fetch_params.svh"

module rv_fetch_inst_sram (
  input  logic                     i_clk,
  // fetch side
  input  logic                     i_ren,
  input  rv_fetch_pkg::sram_addr_t i_raddr,
  output rv_fetch_pkg::sram_data_t o_rdata,
  // program load, only while in reset
  input  logic                     i_we,
  input  rv_fetch_pkg::sram_addr_t i_waddr,
  input  rv_fetch_pkg::sram_data_t i_wdata
);

  import rv_fetch_pkg::*;

  sram_data_t mem [`RV_FETCH_SRAM_DEPTH];
  sram_data_t rdata_q;

  always_ff @(posedge i_clk) begin
    if (i_we) begin
      mem[i_waddr] <= i_wdata;
    end
  end

  // output holds its word while ren is low
  always_ff @(posedge i_clk) begin
    if (i_ren) begin
      rdata_q <= mem[i_raddr];
    end
  end

  assign o_rdata = rdata_q;

endmodule

/* src/rv_fetch_if_stage.sv */
// rv_fetch IF stage with pre-IF/IF valid control, jal squash and 32-of-64 instruction select
`include "rv_fetch_params.svh"

module rv_fetch_if_stage (
  input  logic                     i_clk,
  input  logic                     i_reset,
  // allowin from ID
  input  logic                     i_ds_allowin,
  // jal redirect from ID
  input  logic                     i_br_taken,
  // pc block and memory
  input  rv_fetch_pkg::pc_t        i_pc,
  input  rv_fetch_pkg::sram_data_t i_sram_rdata,
  output logic                     o_pc_load,
  // to ID
  output logic                     o_fs_to_ds_valid,
  output rv_fetch_pkg::inst_t      o_fs_inst,
  output rv_fetch_pkg::pc_t        o_fs_pc
);

  import rv_fetch_pkg::*;

  // pre-IF always has a next pc to offer once out of reset
  logic to_fs_valid;
  assign to_fs_valid = ~i_reset;

  logic fs_valid;
  logic fs_allowin;

  // empty, or current item moves on this edge
  assign fs_allowin = !fs_valid || i_ds_allowin;

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      fs_valid <= 1'b0;
    end else if (fs_allowin) begin
      fs_valid <= to_fs_valid;
    end
  end

  // a jal leaving ID implies ds_allowin, so the target is always loaded
  // and shows up in IF next cycle
  assign o_pc_load = (to_fs_valid && fs_allowin) || i_br_taken;

  // wrong-path inst dropped while the jal leaves ID
  assign o_fs_to_ds_valid = fs_valid && !i_br_taken;

  inst_t inst_lo;
  inst_t inst_hi;

  assign inst_lo = i_sram_rdata[0 +: `RV_FETCH_INST_WD];
  assign inst_hi = i_sram_rdata[`RV_FETCH_INST_WD +: `RV_FETCH_INST_WD];

  // pc[2] picks which half of the word
  assign o_fs_inst = i_pc[2] ? inst_hi : inst_lo;
  assign o_fs_pc   = i_pc;

endmodule

/* src/rv_fetch_id_stage.sv */
// rv_fetch ID stage latches IF output, resolves JAL and drives the branch bus to fetch
module rv_fetch_id_stage (
  input  logic                i_clk,
  input  logic                i_reset,
  // from IF
  input  logic                i_fs_to_ds_valid,
  input  rv_fetch_pkg::inst_t i_fs_inst,
  input  rv_fetch_pkg::pc_t   i_fs_pc,
  // allowin
  input  logic                i_es_allowin,
  output logic                o_ds_allowin,
  // branch bus back to pc and IF
  output logic                o_br_taken,
  output rv_fetch_pkg::pc_t   o_br_target,
  // to execute
  output logic                o_ds_to_es_valid,
  output rv_fetch_pkg::pc_t   o_ds_to_es_pc,
  output rv_fetch_pkg::inst_t o_ds_to_es_inst
);

  import rv_fetch_pkg::*;

  localparam logic [6:0] OPC_JAL = 7'b1101111;

  logic  ds_valid;
  logic  ds_allowin;
  pc_t   ds_pc;
  inst_t ds_inst;

  assign ds_allowin = !ds_valid || i_es_allowin;

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      ds_valid <= 1'b0;
    end else if (ds_allowin) begin
      ds_valid <= i_fs_to_ds_valid;
    end
  end

  // payload only moves on a real transfer
  always_ff @(posedge i_clk) begin
    if (i_fs_to_ds_valid && ds_allowin) begin
      ds_pc   <= i_fs_pc;
      ds_inst <= i_fs_inst;
    end
  end

  logic is_jal;
  pc_t  j_imm;

  assign is_jal = (ds_inst[6:0] == OPC_JAL);

  // J-type immediate with bit 0 always zero
  assign j_imm = {{11{ds_inst[31]}}, ds_inst[31], ds_inst[19:12],
                  ds_inst[20], ds_inst[30:21], 1'b0};

  assign o_br_target = ds_pc + j_imm;

  // pulse as the jal leaves and never while held
  assign o_br_taken = ds_valid && is_jal && i_es_allowin;

  assign o_ds_allowin     = ds_allowin;
  assign o_ds_to_es_valid = ds_valid;
  assign o_ds_to_es_pc    = ds_pc;
  assign o_ds_to_es_inst  = ds_inst;

endmodule

/* src/rv_fetch_top.sv */
// rv_fetch top: pc block, instruction memory, IF and ID stages of the fetch front end
module rv_fetch_top (
  input  logic                     i_clk,
  input  logic                     i_reset,
  // execute side
  input  logic                     i_es_allowin,
  output logic                     o_ds_to_es_valid,
  output rv_fetch_pkg::pc_t        o_ds_to_es_pc,
  output rv_fetch_pkg::inst_t      o_ds_to_es_inst,
  // program load port
  input  logic                     i_imem_we,
  input  rv_fetch_pkg::sram_addr_t i_imem_waddr,
  input  rv_fetch_pkg::sram_data_t i_imem_wdata
);

  import rv_fetch_pkg::*;

  pc_t        pc;
  logic       pc_load;
  logic       sram_ren;
  sram_addr_t sram_addr;
  sram_data_t sram_rdata;

  logic       fs_to_ds_valid;
  inst_t      fs_inst;
  pc_t        fs_pc;
  logic       ds_allowin;

  logic       ds_br_taken;   // jal leaving ID
  pc_t        ds_br_target;

  rv_fetch_pc u_pc (
    .i_clk        (i_clk),
    .i_reset      (i_reset),
    .i_load       (pc_load),
    .i_br_taken   (ds_br_taken),
    .i_br_target  (ds_br_target),
    .o_pc         (pc),
    .o_sram_ren   (sram_ren),
    .o_sram_addr  (sram_addr)
  );

  rv_fetch_inst_sram u_inst_sram (
    .i_clk    (i_clk),
    .i_ren    (sram_ren),
    .i_raddr  (sram_addr),
    .o_rdata  (sram_rdata),
    .i_we     (i_imem_we),
    .i_waddr  (i_imem_waddr),
    .i_wdata  (i_imem_wdata)
  );

  rv_fetch_if_stage u_if_stage (
    .i_clk             (i_clk),
    .i_reset           (i_reset),
    .i_ds_allowin      (ds_allowin),
    .i_br_taken        (ds_br_taken),
    .i_pc              (pc),
    .i_sram_rdata      (sram_rdata),
    .o_pc_load         (pc_load),
    .o_fs_to_ds_valid  (fs_to_ds_valid),
    .o_fs_inst         (fs_inst),
    .o_fs_pc           (fs_pc)
  );

  rv_fetch_id_stage u_id_stage (
    .i_clk             (i_clk),
    .i_reset           (i_reset),
    .i_fs_to_ds_valid  (fs_to_ds_valid),
    .i_fs_inst         (fs_inst),
    .i_fs_pc           (fs_pc),
    .i_es_allowin      (i_es_allowin),
    .o_ds_allowin      (ds_allowin),
    .o_br_taken        (ds_br_taken),
    .o_br_target       (ds_br_target),
    .o_ds_to_es_valid  (o_ds_to_es_valid),
    .o_ds_to_es_pc     (o_ds_to_es_pc),
    .o_ds_to_es_inst   (o_ds_to_es_inst)
  );

endmodule

/* dv/rv_fetch_tb.sv */
// rv_fetch testbench drives a random program with JALs and back-pressure against a fetch model
`include "rv_fetch_params.svh"

module rv_fetch_tb;

  import rv_fetch_pkg::*;

  localparam int NUM_XFERS      = 400;
  localparam int TIMEOUT_CYCLES = NUM_XFERS * 4 + 50;
  localparam int NUM_INSTS      = `RV_FETCH_SRAM_DEPTH * 2;  // 128 instructions in 512 bytes
  localparam logic [6:0] OPC_JAL = 7'b1101111;

  logic       i_clk;
  logic       i_reset;
  logic       i_es_allowin;
  logic       o_ds_to_es_valid;
  pc_t        o_ds_to_es_pc;
  inst_t      o_ds_to_es_inst;
  logic       i_imem_we;
  sram_addr_t i_imem_waddr;
  sram_data_t i_imem_wdata;

  inst_t       prog [NUM_INSTS];      // program image with one entry per instruction
  int          next_off [NUM_INSTS];  // byte step to the next instruction in program order
  logic [31:0] lfsr_state;
  pc_t         model_pc;              // pc of the next expected transfer
  int          xfer_count = 0;
  int          edges_after_release = 0;
  logic        held_valid;            // output was stalled on the last cycle
  pc_t         held_pc;
  inst_t       held_inst;

  rv_fetch_top rv_fetch_top_inst (
    .i_clk            (i_clk),
    .i_reset          (i_reset),
    .i_es_allowin     (i_es_allowin),
    .o_ds_to_es_valid (o_ds_to_es_valid),
    .o_ds_to_es_pc    (o_ds_to_es_pc),
    .o_ds_to_es_inst  (o_ds_to_es_inst),
    .i_imem_we        (i_imem_we),
    .i_imem_waddr     (i_imem_waddr),
    .i_imem_wdata     (i_imem_wdata)
  );

  initial begin
    i_clk = 1'b0;
    forever #50 i_clk = ~i_clk;
  end

  // fibonacci lfsr with taps 32 22 2 1
  function automatic logic rand_bit();
    logic fb;
    fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], fb};
    return fb;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int k = 0; k < n; k++) begin
      v = {v[30:0], rand_bit()};
    end
    return v;
  endfunction

  // J-type encoding of a byte offset
  function automatic inst_t make_jal(input int offset);
    logic [20:0] off;
    logic [31:0] r;
    off = offset[20:0];
    r   = rand_bits(5);
    return {off[20], off[10:1], off[11], off[19:12], r[4:0], OPC_JAL};
  endfunction

  function automatic inst_t model_inst(input pc_t pc);
    return prog[(pc >> 2) % NUM_INSTS];  // fetch wraps within the image
  endfunction

  // step recorded when the program was built
  function automatic pc_t model_next_pc(input pc_t pc);
    return pc + pc_t'(next_off[(pc >> 2) % NUM_INSTS]);
  endfunction

  task automatic build_program();
    int          t;
    int          off;
    logic [31:0] r;
    for (int i = 0; i < NUM_INSTS; i++) begin
      off = 0;
      if (i == 1) begin
        off = 4;  // jal to its own pc + 4
      end else if (i == 2) begin
        off = (40 - 2) * 4;  // back-to-back jals 2, 40, then 3
      end else if (i == 40) begin
        off = (3 - 40) * 4;
      end else if (rand_bits(3) == 0) begin
        // forward jump that may wrap to the start of the image
        t   = (i + 1 + int'(rand_bits(5))) % NUM_INSTS;
        off = (t - i) * 4;
      end
      if (off != 0) begin
        prog[i]     = make_jal(off);
        next_off[i] = off;
      end else begin
        r = rand_bits(32);
        if (r[6:0] == OPC_JAL) begin
          r[3] = 1'b0;
        end
        prog[i]     = r;
        next_off[i] = 4;
      end
    end
  endtask

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("Test failures found");
    $fatal(1);
  endtask

  task automatic check_pc(input string name, input pc_t got, input pc_t exp);
    if (got !== exp) begin
      stop_run($sformatf("FAILED %s: got 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_inst(input string name, input inst_t got, input inst_t exp);
    if (got !== exp) begin
      stop_run($sformatf("FAILED %s: got 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  initial begin
    lfsr_state   = 32'h4937_18db;
    model_pc     = `RV_FETCH_PC_RESETVAL;
    held_valid   = 1'b0;
    i_reset      = 1'b1;
    i_es_allowin = 1'b0;
    i_imem_we    = 1'b0;
    i_imem_waddr = '0;
    i_imem_wdata = '0;
    build_program();
    for (int w = 0; w < `RV_FETCH_SRAM_DEPTH; w++) begin
      @(posedge i_clk);
      #10;
      i_imem_we    = 1'b1;
      i_imem_waddr = sram_addr_t'(w);
      i_imem_wdata = {prog[2*w+1], prog[2*w]};  // lower pc in the low half
    end
    @(posedge i_clk);
    #10;
    i_imem_we = 1'b0;
    repeat (4) @(posedge i_clk);  // reset still high for 4 cycles after load
    #10;
    i_reset      = 1'b0;
    i_es_allowin = (rand_bits(2) != 0);
    forever begin
      @(posedge i_clk);
      #10;
      i_es_allowin = (rand_bits(2) != 0);  // low about one cycle in four
    end
  end

  // edges since reset release bound the run
  always @(posedge i_clk) begin
    if (i_reset) begin
      edges_after_release = 0;
    end else begin
      edges_after_release = edges_after_release + 1;
      if (edges_after_release > TIMEOUT_CYCLES) begin
        stop_run($sformatf("timeout after %0d cycles with only %0d of %0d transfers seen",
                           TIMEOUT_CYCLES, xfer_count, NUM_XFERS));
      end
    end
  end

  // sampled mid-cycle where outputs and allowin are settled
  always @(negedge i_clk) begin
    if (i_reset) begin
      if (o_ds_to_es_valid !== 1'b0) begin
        stop_run("output valid is high while reset is asserted");
      end
    end else begin
      if (edges_after_release < 2 && o_ds_to_es_valid !== 1'b0) begin
        stop_run("output valid came up before the second clock edge after reset release");
      end
      if (edges_after_release == 2 && o_ds_to_es_valid !== 1'b1) begin
        stop_run("output valid is not high two clock edges after reset release");
      end
      if (held_valid) begin
        if (o_ds_to_es_valid !== 1'b1) begin
          stop_run("output valid dropped while the output was held by back-pressure");
        end
        check_pc("o_ds_to_es_pc", o_ds_to_es_pc, held_pc);
        check_inst("o_ds_to_es_inst", o_ds_to_es_inst, held_inst);
      end
      held_valid = (o_ds_to_es_valid === 1'b1) && !i_es_allowin;
      held_pc    = o_ds_to_es_pc;
      held_inst  = o_ds_to_es_inst;
      if (o_ds_to_es_valid === 1'b1 && i_es_allowin) begin
        check_pc("o_ds_to_es_pc", o_ds_to_es_pc, model_pc);
        check_inst("o_ds_to_es_inst", o_ds_to_es_inst, model_inst(model_pc));
        model_pc   = model_next_pc(model_pc);
        xfer_count = xfer_count + 1;
      end
    end
  end

  initial begin
    wait (xfer_count == NUM_XFERS);
    $display("All tests passed!");
    $finish;
  end

endmodule

/* rv_fetch.f */
+incdir+src
src/rv_fetch_pkg.sv
src/rv_fetch_pc.sv
src/rv_fetch_inst_sram.sv
src/rv_fetch_if_stage.sv
src/rv_fetch_id_stage.sv
src/rv_fetch_top.sv
dv/rv_fetch_tb.sv
